// File: all.f
+incdir+testbench
design/splicer_pkg.sv
design/channel_capture.sv
design/memory_arbiter.sv
design/frame_ram.sv
design/display_scanout.sv
design/video_splicer_top.sv
testbench/tb_video_splicer.sv

// File: Bender.yml
package:
  name: video_splicer

sources:
  - files:
      - design/splicer_pkg.sv
      - design/channel_capture.sv
      - design/memory_arbiter.sv
      - design/frame_ram.sv
      - design/display_scanout.sv
      - design/video_splicer_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_video_splicer.sv

// File: testbench/tb_checks.svh
// typed compare tasks and test counters, included inside the splicer testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int checks_run;
int errors;
int tests_run;
int tests_ok;
int test_start_errors;	// error count when the current test began

task automatic check_pixel(input pixel_t actual, input pixel_t expected, input string msg);
	checks_run++;
	if (actual !== expected) begin
		errors++;
		$display("FAIL %0t: %s, got %h expected %h", $time, msg, actual, expected);
	end
endtask

task automatic check_level(input logic actual, input logic expected, input string msg);
	checks_run++;
	if (actual !== expected) begin
		errors++;
		$display("FAIL %0t: %s, got %b expected %b", $time, msg, actual, expected);
	end
endtask

task automatic check_count(input int actual, input int expected, input string msg);
	checks_run++;
	if (actual != expected) begin
		errors++;
		$display("FAIL %0t: %s, got %0d expected %0d", $time, msg, actual, expected);
	end
endtask

task automatic begin_test();
	test_start_errors = errors;
endtask

task automatic end_test(input string name);
	tests_run++;
	if (errors == test_start_errors) begin
		tests_ok++;
		$display("test %s: ok", name);
	end else begin
		$display("test %s: failed with %0d errors", name, errors - test_start_errors);
	end
endtask

`endif

// File: testbench/tb_video_splicer.sv
// top-level testbench that feeds four capture channels and checks every pixel the splicer scans out
`default_nettype none

module tb_video_splicer
	import splicer_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_SIZE  = 16;
	localparam int V_SIZE  = 8;
	localparam int H_BLANK = 4;
	localparam int Q_W     = H_SIZE / 2;
	localparam int Q_H     = V_SIZE / 2;
	localparam int NPIX    = H_SIZE * V_SIZE;
	localparam int DRAIN   = 4 * Q_W * Q_H + H_SIZE;	// FIFOs empty after this
	localparam int TIMEOUT = 4 * V_SIZE * (H_SIZE + H_BLANK);

	typedef pixel_t frame_set_t [NUM_CH][V_SIZE][H_SIZE];

	logic       I0_clk;
	logic       rst_n;
	logic       frame_start;
	video_in_t  ch_in [NUM_CH];
	video_out_t video_out;

	frame_set_t frames;	// last frames sent to the channels
	integer     seed;
	logic       compare_on;
	int         pix_count;
	int         vs_count;
	int         first_de_vs;

	`include "tb_checks.svh"

	video_splicer_top uut (
		.I0_clk      (I0_clk),
		.rst_n       (rst_n),
		.ch_in       (ch_in),
		.frame_start (frame_start),
		.video_out   (video_out)
	);

	always #10 I0_clk = ~I0_clk;

	// decimate, pack to RGB565 and expand back per quadrant
	function automatic pixel_t expected_pixel(input frame_set_t f, input int x, input int y);
		int     c;
		pixel_t src;
		pixel_t res;
		c     = (x >= Q_W ? 1 : 0) + (y >= Q_H ? 2 : 0);
		src   = f[c][2 * (y % Q_H)][2 * (x % Q_W)];
		res   = '0;
		res.r = {src.r[7:3], 3'b000};
		res.g = {src.g[7:2], 2'b00};
		res.b = {src.b[7:3], 3'b000};
		return res;
	endfunction

	task automatic next_cycle();
		@(posedge I0_clk);
		#2;
	endtask

	task automatic fill_random();
		for (int c = 0; c < NUM_CH; c++) begin
			for (int y = 0; y < V_SIZE; y++) begin
				for (int x = 0; x < H_SIZE; x++) begin
					frames[c][y][x] = pixel_t'({8'h00, 24'($random(seed))});
				end
			end
		end
	endtask

	task automatic fill_patterns();
		pixel_t patterns [8];
		patterns = '{32'h00ffffff, 32'h00aaaaaa, 32'h00555555, 32'h00ff0000,
			32'h0000ff00, 32'h000000ff, 32'h00000000, 32'h00f0f0f0};
		for (int c = 0; c < NUM_CH; c++) begin
			for (int y = 0; y < V_SIZE; y++) begin
				for (int x = 0; x < H_SIZE; x++) begin
					frames[c][y][x] = patterns[(c + x / 2 + y / 2) % 8];	// vary over kept pixels
				end
			end
		end
	endtask

	// one frame on all four channels at once, then let the FIFOs drain
	task automatic send_frames();
		for (int c = 0; c < NUM_CH; c++) begin
			ch_in[c].vs = 1'b1;
		end
		next_cycle();
		for (int c = 0; c < NUM_CH; c++) begin
			ch_in[c].vs = 1'b0;
		end
		for (int y = 0; y < V_SIZE; y++) begin
			for (int x = 0; x < H_SIZE; x++) begin
				for (int c = 0; c < NUM_CH; c++) begin
					ch_in[c].de    = 1'b1;
					ch_in[c].pixel = frames[c][y][x];
				end
				next_cycle();
			end
			for (int c = 0; c < NUM_CH; c++) begin
				ch_in[c].de    = 1'b0;
				ch_in[c].pixel = '0;
			end
			next_cycle();	// gap between lines
		end
		repeat (DRAIN) next_cycle();
	endtask

	// strobe frame_start, wait for the whole frame, optionally strobe again halfway
	task automatic run_frame(input int restart_at);
		int   cycles;
		logic restarted;
		vs_count    = 0;
		pix_count   = 0;
		first_de_vs = -1;
		restarted   = 1'b0;
		frame_start = 1'b1;
		next_cycle();
		frame_start = 1'b0;
		cycles      = 0;
		while (pix_count < NPIX && cycles < TIMEOUT) begin
			frame_start = 1'b0;
			if (restart_at > 0 && !restarted && pix_count >= restart_at) begin
				frame_start = 1'b1;
				restarted   = 1'b1;
			end
			next_cycle();
			cycles++;
		end
		frame_start = 1'b0;
		if (pix_count < NPIX) begin
			errors++;
			$display("timeout: only %0d of %0d display pixels arrived", pix_count, NPIX);
		end else begin
			repeat (H_BLANK + 4) next_cycle();	// tail of the last line
			check_count(pix_count, NPIX, "display pixel count");
			check_count(vs_count, 1, "vs pulses in the frame");
			check_count(first_de_vs, 1, "vs pulses before the first de");
		end
	endtask

	// compare process sampled mid-cycle
	always @(negedge I0_clk) begin
		if (rst_n) begin
			if (video_out.vs) begin
				vs_count++;
			end
			if (video_out.de) begin
				if (pix_count == 0) begin
					first_de_vs = vs_count;
				end
				check_level(|{video_out.pixel.zero, video_out.pixel.r[2:0],
					video_out.pixel.g[1:0], video_out.pixel.b[2:0]}, 1'b0,
					"low bits of the expanded pixel");
				if (compare_on) begin
					check_pixel(video_out.pixel,
						expected_pixel(frames, pix_count % H_SIZE, pix_count / H_SIZE),
						$sformatf("pixel x=%0d y=%0d", pix_count % H_SIZE, pix_count / H_SIZE));
				end
				pix_count++;
			end
		end
	end

	initial begin
		I0_clk      = 1'b0;
		rst_n       = 1'b0;
		frame_start = 1'b0;
		seed        = 92948;
		compare_on  = 1'b0;
		checks_run  = 0;
		errors      = 0;
		tests_run   = 0;
		tests_ok    = 0;
		for (int c = 0; c < NUM_CH; c++) begin
			ch_in[c] = '0;
		end
		repeat (4) @(posedge I0_clk);
		#2;
		rst_n = 1'b1;

		begin_test();
		repeat (20) begin
			next_cycle();
			check_level(video_out.de, 1'b0, "de before any frame_start");
			check_level(video_out.vs, 1'b0, "vs before any frame_start");
		end
		end_test("reset");

		fill_random();
		send_frames();
		begin_test();
		run_frame(0);
		end_test("frame structure");

		compare_on = 1'b1;	// same memory contents compared pixel by pixel
		begin_test();
		run_frame(0);
		end_test("splicing");

		begin_test();
		fill_patterns();
		send_frames();
		run_frame(0);
		end_test("color conversion");

		begin_test();
		fill_random();
		send_frames();
		run_frame(0);
		end_test("overwrite");

		begin_test();
		run_frame(NPIX / 2);
		end_test("ignored restart");

		$display("tests %0d of %0d ok, checks %0d run, %0d failed",
			tests_ok, tests_run, checks_run, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/video_splicer_top.sv
// four-channel video splicer top level, connecting captures, arbiter, frame memory and scan-out
`default_nettype none

module video_splicer_top
	import splicer_pkg::*;
#(
	parameter int H_SIZE     = 16,
	parameter int V_SIZE     = 8,
	parameter int H_BLANK    = 4,
	parameter int FIFO_DEPTH = H_SIZE / 2
) (
	input  logic       I0_clk,
	input  logic       rst_n,
	input  video_in_t  ch_in [NUM_CH],
	input  logic       frame_start,
	output video_out_t video_out
);

	wr_req_t           wr_req [NUM_CH];
	logic [NUM_CH-1:0] grant;
	logic              rd_req;
	addr_t             rd_addr;
	mem_cmd_t          mem_cmd;
	rgb565_t           rd_data;

	// one writer per quadrant
	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		channel_capture #(
			.H_SIZE     (H_SIZE),
			.V_SIZE     (V_SIZE),
			.FIFO_DEPTH (FIFO_DEPTH),
			.CH_INDEX   (c)
		) u_capture (
			.I0_clk (I0_clk),
			.rst_n  (rst_n),
			.video  (ch_in[c]),
			.wr_req (wr_req[c]),
			.grant  (grant[c])
		);
	end

	memory_arbiter #(
		.H_SIZE (H_SIZE),
		.V_SIZE (V_SIZE)
	) u_arbiter (
		.I0_clk  (I0_clk),
		.rst_n   (rst_n),
		.wr_req  (wr_req),
		.grant   (grant),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.mem_cmd (mem_cmd)
	);

	frame_ram #(
		.H_SIZE (H_SIZE),
		.V_SIZE (V_SIZE)
	) u_frame_ram (
		.I0_clk  (I0_clk),
		.mem_cmd (mem_cmd),
		.rd_data (rd_data)
	);

	display_scanout #(
		.H_SIZE  (H_SIZE),
		.V_SIZE  (V_SIZE),
		.H_BLANK (H_BLANK)
	) u_scanout (
		.I0_clk      (I0_clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.video       (video_out)
	);

endmodule

`default_nettype wire

// File: design/display_scanout.sv
// output raster generator: reads the spliced frame in raster order and expands RGB565 to 32 bits
`default_nettype none

module display_scanout
	import splicer_pkg::*;
#(
	parameter int H_SIZE  = 16,
	parameter int V_SIZE  = 8,
	parameter int H_BLANK = 4
) (
	input  logic       I0_clk,
	input  logic       rst_n,
	input  logic       frame_start,
	output logic       rd_req,
	output addr_t      rd_addr,
	input  rgb565_t    rd_data,
	output video_out_t video
);

	localparam int H_TOTAL = H_SIZE + H_BLANK;
	localparam int Q_W     = H_SIZE / 2;
	localparam int Q_H     = V_SIZE / 2;
	localparam int H_W     = $clog2(H_TOTAL);
	localparam int V_W     = (V_SIZE > 1) ? $clog2(V_SIZE) : 1;

	scan_state_t    state;
	logic [H_W-1:0] h_cnt;
	logic [V_W-1:0] v_cnt;
	logic           start;
	logic           line_end;
	logic [1:0]     vs_pipe;
	logic [1:0]     de_pipe;

	assign start    = frame_start && (state == SCAN_IDLE);	// restarts mid-frame are dropped
	assign line_end = (h_cnt == H_W'(H_TOTAL - 1));

	always_ff @(posedge I0_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SCAN_IDLE;
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (start) begin
						state <= SCAN_RUN;
						h_cnt <= '0;
						v_cnt <= '0;
					end
				end
				SCAN_RUN: begin
					if (line_end) begin
						h_cnt <= '0;
						if (v_cnt == V_W'(V_SIZE - 1)) begin
							state <= SCAN_IDLE;	// no vertical blank
						end else begin
							v_cnt <= v_cnt + 1'b1;
						end
					end else begin
						h_cnt <= h_cnt + 1'b1;
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	assign rd_req = (state == SCAN_RUN) && (h_cnt < H_W'(H_SIZE));

	// quadrant select and local position
	always_comb begin
		int quad;
		int lx;
		int ly;
		quad = 0;
		lx   = int'(h_cnt);
		ly   = int'(v_cnt);
		if (lx >= Q_W) begin
			quad += 1;
			lx   -= Q_W;
		end
		if (ly >= Q_H) begin
			quad += 2;
			ly   -= Q_H;
		end
		rd_addr = addr_t'(quad * Q_W * Q_H + ly * Q_W + lx);
	end

	// arbiter register plus ram register
	always_ff @(posedge I0_clk or negedge rst_n) begin
		if (!rst_n) begin
			vs_pipe <= '0;
			de_pipe <= '0;
		end else begin
			vs_pipe <= {vs_pipe[0], start};
			de_pipe <= {de_pipe[0], rd_req};
		end
	end

	always_comb begin
		video.vs    = vs_pipe[1];
		video.de    = de_pipe[1];
		video.pixel = '0;
		if (de_pipe[1]) begin
			video.pixel.r = {rd_data.r, 3'b000};	// low bits zero
			video.pixel.g = {rd_data.g, 2'b00};
			video.pixel.b = {rd_data.b, 3'b000};
		end
	end

	// reads still in flight may drain just after the frame
	a_idle_no_de: assert property (@(posedge I0_clk) disable iff (!rst_n)
		(state == SCAN_IDLE)[*3] |-> !video.de);

endmodule

`default_nettype wire

// File: design/frame_ram.sv
// single-port frame store holding the four RGB565 quadrants, driven by the arbiter command
`default_nettype none

module frame_ram
	import splicer_pkg::*;
#(
	parameter int H_SIZE = 16,
	parameter int V_SIZE = 8
) (
	input  logic     I0_clk,
	input  mem_cmd_t mem_cmd,
	output rgb565_t  rd_data
);

	localparam int DEPTH = H_SIZE * V_SIZE;	// 4 x (H/2 x V/2)
	localparam int IDX_W = addr_bits(H_SIZE, V_SIZE);

	rgb565_t          ram [DEPTH];
	logic [IDX_W-1:0] idx;

	assign idx = mem_cmd.addr[IDX_W-1:0];

	always_ff @(posedge I0_clk) begin
		if (mem_cmd.op == MEM_WRITE) begin
			ram[idx] <= mem_cmd.data;
		end else if (mem_cmd.op == MEM_READ) begin
			rd_data <= ram[idx];	// valid the cycle after the command
		end
	end

endmodule

`default_nettype wire

// File: design/memory_arbiter.sv
// shares the single frame memory port between the scan-out reader and the four capture writers
`default_nettype none

module memory_arbiter
	import splicer_pkg::*;
#(
	parameter int H_SIZE = 16,
	parameter int V_SIZE = 8
) (
	input  logic              I0_clk,
	input  logic              rst_n,
	input  wr_req_t           wr_req [NUM_CH],
	output logic [NUM_CH-1:0] grant,
	input  logic              rd_req,
	input  addr_t             rd_addr,
	output mem_cmd_t          mem_cmd
);

	localparam int MEM_WORDS = H_SIZE * V_SIZE;	// four quadrants together
	localparam int IDX_W     = $clog2(NUM_CH);

	logic [IDX_W-1:0] rr_ptr;
	logic [IDX_W-1:0] win_idx;
	logic             win_valid;
	mem_cmd_t         cmd_next;

	// first valid writer at or after the pointer
	always_comb begin
		logic [IDX_W-1:0] idx;
		win_idx   = rr_ptr;
		win_valid = 1'b0;
		for (int i = 0; i < NUM_CH; i++) begin
			idx = rr_ptr + IDX_W'(i);	// wraps around the ring
			if (!win_valid && wr_req[idx].valid) begin
				win_valid = 1'b1;
				win_idx   = idx;
			end
		end
	end

	always_comb begin
		grant = '0;
		if (!rd_req && win_valid) begin	// reader always wins
			grant[win_idx] = 1'b1;
		end
	end

	always_comb begin
		cmd_next = '{op: MEM_IDLE, addr: '0, data: '0};
		if (rd_req) begin
			cmd_next.op   = MEM_READ;
			cmd_next.addr = rd_addr;
		end else if (win_valid) begin
			cmd_next.op   = MEM_WRITE;
			cmd_next.addr = wr_req[win_idx].addr;
			cmd_next.data = wr_req[win_idx].data;
		end
	end

	always_ff @(posedge I0_clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_cmd <= '{op: MEM_IDLE, addr: '0, data: '0};
			rr_ptr  <= '0;
		end else begin
			mem_cmd <= cmd_next;
			if (!rd_req && win_valid) begin
				rr_ptr <= win_idx + 1'b1;	// next search starts past the winner
			end
		end
	end

	a_one_grant: assert property (@(posedge I0_clk) disable iff (!rst_n)
		$onehot0(grant));

	a_read_first: assert property (@(posedge I0_clk) disable iff (!rst_n)
		rd_req |-> (grant == '0));

	// requesters must stay inside the four quadrants
	a_addr_range: assert property (@(posedge I0_clk) disable iff (!rst_n)
		(mem_cmd.op != MEM_IDLE) |-> (mem_cmd.addr < ADDR_W'(MEM_WORDS)));

endmodule

`default_nettype wire

// File: design/channel_capture.sv
// one input channel: 2x2 decimation, RGB565 packing and a write queue toward the memory arbiter
`default_nettype none

module channel_capture
	import splicer_pkg::*;
#(
	parameter int H_SIZE     = 16,
	parameter int V_SIZE     = 8,
	parameter int FIFO_DEPTH = H_SIZE / 2,
	parameter int CH_INDEX   = 0
) (
	input  logic      I0_clk,
	input  logic      rst_n,
	input  video_in_t video,
	output wr_req_t   wr_req,
	input  logic      grant
);

	localparam int Q_W   = H_SIZE / 2;
	localparam int Q_H   = V_SIZE / 2;
	localparam int BASE  = CH_INDEX * Q_W * Q_H;	// first word of this quadrant
	localparam int X_W   = (H_SIZE > 1) ? $clog2(H_SIZE) : 1;
	localparam int Y_W   = (V_SIZE > 1) ? $clog2(V_SIZE) : 1;
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef struct packed {
		addr_t   addr;
		rgb565_t data;
	} entry_t;

	logic [X_W-1:0]   x_cnt;
	logic [Y_W-1:0]   y_cnt;
	logic             keep;
	logic             push;
	logic             pop;
	logic             full;
	entry_t           push_entry;
	entry_t           fifo_mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge I0_clk or negedge rst_n) begin
		if (!rst_n) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (video.vs) begin	// new input frame
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (video.de) begin
			if (x_cnt == X_W'(H_SIZE - 1)) begin
				x_cnt <= '0;
				y_cnt <= (y_cnt == Y_W'(V_SIZE - 1)) ? '0 : y_cnt + 1'b1;
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

	assign keep = video.de && !x_cnt[0] && !y_cnt[0];	// top-left of each 2x2 block

	always_comb begin
		push_entry.addr   = addr_t'(BASE + int'(y_cnt >> 1) * Q_W + int'(x_cnt >> 1));
		push_entry.data.r = video.pixel.r[7:3];	// keep the msbs
		push_entry.data.g = video.pixel.g[7:2];
		push_entry.data.b = video.pixel.b[7:3];
	end

	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign pop  = grant && wr_req.valid;
	assign push = keep && (!full || pop);	// head slot frees up on a pop

	always_ff @(posedge I0_clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge I0_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_comb begin
		wr_req.valid = (count != '0);
		wr_req.addr  = fifo_mem[rd_ptr].addr;	// head waits here until granted
		wr_req.data  = fifo_mem[rd_ptr].data;
	end

	// a kept pixel that finds no room is lost from the quadrant
	a_no_overflow: assert property (@(posedge I0_clk) disable iff (!rst_n)
		keep |-> (!full || pop));

	a_grant_valid: assert property (@(posedge I0_clk) disable iff (!rst_n)
		grant |-> wr_req.valid);

endmodule

`default_nettype wire

// File: design/splicer_pkg.sv
// shared pixel, stream, memory command and FSM types, imported by every splicer module
`default_nettype none

package splicer_pkg;

	localparam int NUM_CH = 4;	// fixed by the 2x2 quadrant layout
	localparam int MAX_H  = 256;	// largest active width the address type covers
	localparam int MAX_V  = 256;

	// bits needed to address a whole h x v frame of stored pixels
	function automatic int addr_bits(input int h, input int v);
		return (h * v > 1) ? $clog2(h * v) : 1;
	endfunction

	localparam int ADDR_W = addr_bits(MAX_H, MAX_V);

	typedef logic [ADDR_W-1:0] addr_t;

	typedef struct packed {
		logic [7:0] zero;	// unused top byte
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic   vs;	// one-cycle pulse ahead of a frame
		logic   de;
		pixel_t pixel;
	} video_in_t;

	typedef struct packed {
		logic   vs;
		logic   de;
		pixel_t pixel;
	} video_out_t;

	typedef enum logic [1:0] {
		MEM_IDLE  = 2'd0,
		MEM_WRITE = 2'd1,
		MEM_READ  = 2'd2
	} mem_op_t;

	typedef struct packed {
		mem_op_t op;
		addr_t   addr;
		rgb565_t data;	// write data, ignored on reads
	} mem_cmd_t;

	typedef struct packed {
		logic    valid;
		addr_t   addr;
		rgb565_t data;
	} wr_req_t;

	typedef enum logic {
		SCAN_IDLE = 1'b0,
		SCAN_RUN  = 1'b1
	} scan_state_t;

endpackage

`default_nettype wire
